// ==== design/i3c_target_pkg.sv ====
// Shared definitions for the SDR private-transfer I3C target.
// Byte width is fixed at 8 and address width at 7 by the protocol.
// The state type is visible to the RX and TX paths, which decode
// the FSM's current and next state.
package i3c_target_pkg;

  // Width of a target address on the bus
  localparam int unsigned ADDR_W = 7;

  // One byte as sent on SDA
  typedef logic [7:0] byte_t;

  // Target address without the RnW bit
  typedef logic [ADDR_W-1:0] addr_t;

  // Broadcast address 7E with the write bit
  localparam byte_t RSVD_BYTE = 8'hFC;

  // Primary transfer states
  typedef enum logic [7:0] {
    // Wait for START
    IDLE,
    // First byte after START, checked against our addresses
    RX_FBYTE,
    CHECK_FBYTE,
    TX_ACK_FBYTE,
    // Byte after a broadcast ACK; a repeated START means a new address follows
    RX_SBYTE,
    RX_SBYTE_REP,
    CHECK_SBYTE,
    TX_ACK_SBYTE,
    // Private write loop
    RX_PWRITE_DATA,
    RX_PWRITE_TBIT,
    // Private read loop
    TX_PREAD_DATA,
    TX_PREAD_TBIT,
    // Not for us, wait for repeated START or STOP
    WAIT
  } target_state_e;

endpackage

// ==== design/target_addr_match.sv ====
// Address byte capture and match decode for own, virtual and broadcast.
// A valid dynamic address hides the static one of the same device.
// Match outputs come from the stored byte, so they are valid one cycle
// after the capture strobe.
`timescale 1ns/1ps

module target_addr_match import i3c_target_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  addr_capture_i,
  input  byte_t bus_rx_data_i,
  input  logic  target_idle_i,
  input  logic  start_any_i,
  input  addr_t target_sta_address_i,
  input  logic  target_sta_address_valid_i,
  input  addr_t target_dyn_address_i,
  input  logic  target_dyn_address_valid_i,
  input  addr_t virtual_sta_address_i,
  input  logic  virtual_sta_address_valid_i,
  input  addr_t virtual_dyn_address_i,
  input  logic  virtual_dyn_address_valid_i,
  output logic  own_match_o,
  output logic  virt_match_o,
  output logic  rsvd_match_o,
  output logic  rnw_o,
  output byte_t last_addr_o,
  output logic  last_addr_valid_o
);

  addr_t addr_q;
  logic  rnw_q;

  // Dynamic address wins whenever it is valid
  function automatic logic addr_hit(addr_t dyn, logic dyn_v, addr_t sta, logic sta_v,
                                    addr_t bus_addr);
    if (dyn_v) begin
      return dyn == bus_addr;
    end
    return sta_v && (sta == bus_addr);
  endfunction

  // Address and RnW, cleared while the FSM idles
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
      rnw_q  <= 1'b0;
    end else if (addr_capture_i) begin
      addr_q <= bus_rx_data_i[7:1];
      rnw_q  <= bus_rx_data_i[0];
    end else if (target_idle_i) begin
      addr_q <= '0;
      rnw_q  <= 1'b0;
    end
  end

  // Stale on every START until the next address arrives
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_addr_valid_o <= 1'b0;
    end else if (start_any_i) begin
      last_addr_valid_o <= 1'b0;
    end else if (addr_capture_i) begin
      last_addr_valid_o <= 1'b1;
    end
  end

  assign own_match_o  = addr_hit(target_dyn_address_i, target_dyn_address_valid_i,
                                 target_sta_address_i, target_sta_address_valid_i, addr_q);
  assign virt_match_o = addr_hit(virtual_dyn_address_i, virtual_dyn_address_valid_i,
                                 virtual_sta_address_i, virtual_sta_address_valid_i, addr_q);
  // Broadcast is only valid as a write
  assign rsvd_match_o = ({addr_q, rnw_q} == RSVD_BYTE);
  assign rnw_o        = rnw_q;
  assign last_addr_o  = {addr_q, rnw_q};

endmodule

// ==== design/target_fsm.sv ====
// Primary FSM of the target, SDR private transfers only.
// A data byte after a broadcast ACK is not decoded and sends the FSM to WAIT.
// STOP forces IDLE from any state; RX requests are masked during a START.
`timescale 1ns/1ps

module target_fsm import i3c_target_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          target_enable_i,
  input  logic          start_any_i,
  input  logic          bus_stop_det_i,
  input  logic          bus_rx_done_i,
  input  logic          bus_tx_done_i,
  input  logic          own_match_i,
  input  logic          virt_match_i,
  input  logic          rsvd_match_i,
  input  logic          rnw_i,
  input  logic          tx_desc_avail_i,
  input  logic          tx_fifo_rvalid_i,
  input  logic          tx_last_byte_i,
  input  logic          tx_end_xfer_i,
  input  byte_t         tx_data_i,
  output target_state_e state_q_o,
  output target_state_e state_d_o,
  output logic          bus_rx_req_byte_o,
  output logic          bus_rx_req_bit_o,
  output logic          bus_tx_req_byte_o,
  output logic          bus_tx_req_bit_o,
  output byte_t         bus_tx_req_value_o,
  output logic          addr_capture_o,
  output logic          target_idle_o,
  output logic          target_transmitting_o,
  output logic          event_target_nack_o,
  output logic          virtual_device_sel_o,
  output logic          xfer_in_progress_o
);

  target_state_e state_q, state_d;
  logic          any_match;
  logic          in_wait_q;

  assign any_match = own_match_i | virt_match_i;

  // Bus requests held as levels for the whole state
  always_comb begin
    bus_rx_req_byte_o  = 1'b0;
    bus_rx_req_bit_o   = 1'b0;
    bus_tx_req_byte_o  = 1'b0;
    bus_tx_req_bit_o   = 1'b0;
    // SDA released when nothing is driven
    bus_tx_req_value_o = 8'h01;
    addr_capture_o     = 1'b0;
    case (state_q)
      RX_FBYTE, RX_SBYTE_REP: begin
        bus_rx_req_byte_o = ~start_any_i;
        addr_capture_o    = bus_rx_done_i;
      end
      RX_SBYTE, RX_PWRITE_DATA: bus_rx_req_byte_o = ~start_any_i;
      RX_PWRITE_TBIT:           bus_rx_req_bit_o  = ~start_any_i;
      TX_ACK_FBYTE, TX_ACK_SBYTE: begin
        // ACK is SDA low, carried in bit 0
        bus_tx_req_bit_o   = 1'b1;
        bus_tx_req_value_o = '0;
      end
      TX_PREAD_DATA: begin
        bus_tx_req_byte_o  = 1'b1;
        bus_tx_req_value_o = tx_data_i;
      end
      TX_PREAD_TBIT: begin
        // T-bit low ends the read
        bus_tx_req_bit_o   = 1'b1;
        bus_tx_req_value_o = {7'h00, ~tx_end_xfer_i};
      end
      default: ;
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (target_enable_i && start_any_i) state_d = RX_FBYTE;
      RX_FBYTE: if (bus_rx_done_i) state_d = CHECK_FBYTE;
      CHECK_FBYTE: state_d = (rsvd_match_i || any_match) ? TX_ACK_FBYTE : WAIT;
      TX_ACK_FBYTE: begin
        if (bus_tx_done_i) begin
          if (rsvd_match_i)   state_d = RX_SBYTE;
          else if (any_match) state_d = rnw_i ? TX_PREAD_DATA : RX_PWRITE_DATA;
          else                state_d = WAIT;
        end
      end
      // After broadcast ACK: SR brings a new address, a data byte is a CCC
      RX_SBYTE: begin
        if (start_any_i)        state_d = RX_SBYTE_REP;
        else if (bus_rx_done_i) state_d = WAIT;
      end
      RX_SBYTE_REP: if (bus_rx_done_i) state_d = CHECK_SBYTE;
      // Reads are only ACKed with a descriptor ready
      CHECK_SBYTE: begin
        state_d = (any_match && (tx_desc_avail_i || !rnw_i)) ? TX_ACK_SBYTE : WAIT;
      end
      TX_ACK_SBYTE: begin
        if (bus_tx_done_i) begin
          if (any_match) state_d = rnw_i ? TX_PREAD_DATA : RX_PWRITE_DATA;
          else           state_d = WAIT;
        end
      end
      RX_PWRITE_DATA: begin
        if (start_any_i)        state_d = RX_FBYTE;
        else if (bus_rx_done_i) state_d = RX_PWRITE_TBIT;
      end
      RX_PWRITE_TBIT: if (bus_rx_done_i) state_d = RX_PWRITE_DATA;
      TX_PREAD_DATA: begin
        if (start_any_i)        state_d = RX_FBYTE;
        else if (bus_tx_done_i) state_d = TX_PREAD_TBIT;
      end
      TX_PREAD_TBIT: begin
        if (start_any_i) begin
          state_d = RX_FBYTE;
        end else if (bus_tx_done_i) begin
          // More data unless the previous T-bit closed the read
          if ((tx_fifo_rvalid_i || tx_last_byte_i) && !tx_end_xfer_i) state_d = TX_PREAD_DATA;
          else state_d = WAIT;
        end
      end
      WAIT: if (start_any_i) state_d = RX_FBYTE;
      default: state_d = IDLE;
    endcase
    if (bus_stop_det_i) state_d = IDLE;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      in_wait_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      in_wait_q <= (state_q == WAIT);
    end
  end

  // Selection status is judged in the check states only
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      virtual_device_sel_o <= 1'b0;
      xfer_in_progress_o   <= 1'b0;
    end else begin
      case (state_q)
        IDLE: xfer_in_progress_o <= 1'b0;
        CHECK_FBYTE, CHECK_SBYTE: begin
          xfer_in_progress_o <= any_match;
          if (!rsvd_match_i) virtual_device_sel_o <= virt_match_i;
        end
        default: ;
      endcase
    end
  end

  assign state_q_o             = state_q;
  assign state_d_o             = state_d;
  assign target_idle_o         = (state_q == IDLE);
  assign target_transmitting_o = state_q inside {TX_ACK_FBYTE, TX_ACK_SBYTE,
                                                 TX_PREAD_DATA, TX_PREAD_TBIT};
  // First cycle in WAIT
  assign event_target_nack_o   = (state_q == WAIT) && !in_wait_q;

endmodule

// ==== design/target_rx_path.sv ====
// Private write data path: byte register, T-bit check and RX FIFO push.
// A parity error blocks every later byte of the transfer until idle.
// A byte whose reception starts while the FIFO is not ready is dropped.
`timescale 1ns/1ps

module target_rx_path import i3c_target_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  target_state_e state_q_i,
  input  target_state_e state_d_i,
  input  logic          bus_rx_done_i,
  input  logic          bus_rx_req_byte_i,
  input  byte_t         bus_rx_data_i,
  input  logic          rx_fifo_wready_i,
  input  logic          target_idle_i,
  output logic          rx_fifo_wvalid_o,
  output byte_t         rx_fifo_wdata_o,
  output logic          rx_last_byte_o,
  output logic          parity_err_o,
  output logic          rx_overflow_err_o
);

  byte_t last_byte_q;
  logic  parity_bit;
  logic  parity_err_q;
  logic  enter_data;
  logic  ovf_q, ovf_pulse_q;
  logic  wvalid_set;

  // Last full byte seen on the bus
  always_ff @(posedge clk_i) begin
    if (bus_rx_done_i && bus_rx_req_byte_i) last_byte_q <= bus_rx_data_i;
  end

  // Odd parity over byte and T-bit
  assign parity_bit   = ^{last_byte_q, 1'b1};
  assign parity_err_o = (state_q_i == RX_PWRITE_TBIT) && bus_rx_done_i &&
                        (bus_rx_data_i[0] != parity_bit);

  assign enter_data = (state_d_i == RX_PWRITE_DATA) && (state_q_i != RX_PWRITE_DATA);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      parity_err_q <= 1'b0;
      ovf_q        <= 1'b0;
      ovf_pulse_q  <= 1'b0;
    end else begin
      if (parity_err_o)       parity_err_q <= 1'b1;
      else if (target_idle_i) parity_err_q <= 1'b0;
      // Overflow is judged per byte at its first cycle
      ovf_pulse_q <= enter_data && !rx_fifo_wready_i;
      if (enter_data)         ovf_q <= !rx_fifo_wready_i;
      else if (target_idle_i) ovf_q <= 1'b0;
    end
  end

  // Completed T-bit with no error on this byte or earlier ones
  assign wvalid_set = (state_q_i == RX_PWRITE_TBIT) && (state_d_i != RX_PWRITE_TBIT) &&
                      bus_rx_done_i && !(parity_err_o || parity_err_q || ovf_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_fifo_wvalid_o <= 1'b0;
    end else if (wvalid_set) begin
      rx_fifo_wvalid_o <= 1'b1;
    end else if (rx_fifo_wready_i) begin
      rx_fifo_wvalid_o <= 1'b0;
    end
  end

  assign rx_fifo_wdata_o   = last_byte_q;
  assign rx_overflow_err_o = ovf_pulse_q;
  assign rx_last_byte_o    = (state_q_i == RX_PWRITE_DATA) &&
                             (state_d_i inside {IDLE, RX_FBYTE});

endmodule

// ==== design/target_tx_path.sv ====
// Private read data path: TX FIFO pop and byte holding for the PHY.
// The FIFO is popped when the FSM is about to enter a data byte;
// rdata must be valid in that cycle.
`timescale 1ns/1ps

module target_tx_path import i3c_target_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  target_state_e state_q_i,
  input  target_state_e state_d_i,
  input  logic          bus_tx_done_i,
  input  logic          bus_tx_req_bit_i,
  input  byte_t         tx_fifo_rdata_i,
  input  logic          tx_last_byte_i,
  output logic          tx_fifo_rready_o,
  output byte_t         tx_data_o,
  output logic          tx_end_xfer_o
);

  byte_t data_q;
  logic  end_xfer_q;

  // Pop once per data byte
  assign tx_fifo_rready_o = (state_d_i == TX_PREAD_DATA) && (state_q_i != TX_PREAD_DATA);

  always_ff @(posedge clk_i) begin
    if (tx_fifo_rready_o) data_q <= tx_fifo_rdata_i;
  end

  // Last-byte flag sampled at each T-bit, it drives the next T-bit value
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      end_xfer_q <= 1'b0;
    end else if (state_q_i == IDLE) begin
      end_xfer_q <= 1'b0;
    end else if ((state_q_i == TX_PREAD_TBIT) && bus_tx_req_bit_i && bus_tx_done_i) begin
      end_xfer_q <= tx_last_byte_i;
    end
  end

  assign tx_data_o     = data_q;
  assign tx_end_xfer_o = end_xfer_q;

endmodule

// ==== design/i3c_target.sv ====
// I3C target top, SDR private transfers only.
// Bus PHY handshakes are level requests answered by one-cycle done pulses.
// No CCC, IBI or HDR support.
`timescale 1ns/1ps

module i3c_target import i3c_target_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  target_enable_i,
  // Bus PHY
  input  logic  bus_start_det_i,
  input  logic  bus_rstart_det_i,
  input  logic  bus_stop_det_i,
  input  logic  bus_rx_done_i,
  input  byte_t bus_rx_data_i,
  input  logic  bus_tx_done_i,
  output logic  bus_rx_req_byte_o,
  output logic  bus_rx_req_bit_o,
  output logic  bus_tx_req_byte_o,
  output logic  bus_tx_req_bit_o,
  output byte_t bus_tx_req_value_o,
  // Addresses
  input  addr_t target_sta_address_i,
  input  logic  target_sta_address_valid_i,
  input  addr_t target_dyn_address_i,
  input  logic  target_dyn_address_valid_i,
  input  addr_t virtual_sta_address_i,
  input  logic  virtual_sta_address_valid_i,
  input  addr_t virtual_dyn_address_i,
  input  logic  virtual_dyn_address_valid_i,
  // FIFOs
  input  logic  tx_desc_avail_i,
  input  logic  tx_fifo_rvalid_i,
  input  byte_t tx_fifo_rdata_i,
  input  logic  tx_last_byte_i,
  input  logic  rx_fifo_wready_i,
  output logic  tx_fifo_rready_o,
  output logic  rx_fifo_wvalid_o,
  output byte_t rx_fifo_wdata_o,
  output logic  rx_last_byte_o,
  // Status
  output logic  target_idle_o,
  output logic  target_transmitting_o,
  output logic  event_target_nack_o,
  output byte_t last_addr_o,
  output logic  last_addr_valid_o,
  output logic  virtual_device_sel_o,
  output logic  xfer_in_progress_o,
  output logic  parity_err_o,
  output logic  rx_overflow_err_o
);

  target_state_e state_q, state_d;
  logic          start_any;
  logic          addr_capture;
  logic          own_match, virt_match, rsvd_match, rnw;
  logic          tx_end_xfer;
  byte_t         tx_data;

  // START and repeated START act the same
  assign start_any = bus_start_det_i | bus_rstart_det_i;

  target_addr_match u_addr_match (
    .clk_i, .rst_ni,
    .addr_capture_i (addr_capture),
    .bus_rx_data_i,
    .target_idle_i  (target_idle_o),
    .start_any_i    (start_any),
    .target_sta_address_i, .target_sta_address_valid_i,
    .target_dyn_address_i, .target_dyn_address_valid_i,
    .virtual_sta_address_i, .virtual_sta_address_valid_i,
    .virtual_dyn_address_i, .virtual_dyn_address_valid_i,
    .own_match_o    (own_match),
    .virt_match_o   (virt_match),
    .rsvd_match_o   (rsvd_match),
    .rnw_o          (rnw),
    .last_addr_o,
    .last_addr_valid_o
  );

  target_fsm u_fsm (
    .clk_i, .rst_ni, .target_enable_i,
    .start_any_i    (start_any),
    .bus_stop_det_i, .bus_rx_done_i, .bus_tx_done_i,
    .own_match_i    (own_match),
    .virt_match_i   (virt_match),
    .rsvd_match_i   (rsvd_match),
    .rnw_i          (rnw),
    .tx_desc_avail_i, .tx_fifo_rvalid_i, .tx_last_byte_i,
    .tx_end_xfer_i  (tx_end_xfer),
    .tx_data_i      (tx_data),
    .state_q_o      (state_q),
    .state_d_o      (state_d),
    .bus_rx_req_byte_o, .bus_rx_req_bit_o,
    .bus_tx_req_byte_o, .bus_tx_req_bit_o, .bus_tx_req_value_o,
    .addr_capture_o (addr_capture),
    .target_idle_o, .target_transmitting_o, .event_target_nack_o,
    .virtual_device_sel_o, .xfer_in_progress_o
  );

  target_rx_path u_rx_path (
    .clk_i, .rst_ni,
    .state_q_i         (state_q),
    .state_d_i         (state_d),
    .bus_rx_done_i,
    .bus_rx_req_byte_i (bus_rx_req_byte_o),
    .bus_rx_data_i, .rx_fifo_wready_i,
    .target_idle_i     (target_idle_o),
    .rx_fifo_wvalid_o, .rx_fifo_wdata_o, .rx_last_byte_o,
    .parity_err_o, .rx_overflow_err_o
  );

  target_tx_path u_tx_path (
    .clk_i, .rst_ni,
    .state_q_i        (state_q),
    .state_d_i        (state_d),
    .bus_tx_done_i,
    .bus_tx_req_bit_i (bus_tx_req_bit_o),
    .tx_fifo_rdata_i, .tx_last_byte_i, .tx_fifo_rready_o,
    .tx_data_o        (tx_data),
    .tx_end_xfer_o    (tx_end_xfer)
  );

endmodule

// ==== bench/tb_i3c_target.sv ====
// Directed testbench for the SDR private-transfer I3C target.
// A behavioral PHY answers each request after 1 to 4 cycles; inputs change on the falling edge.
// Each wait gives up after TMO cycles.
`timescale 1ns/1ps

module tb_i3c_target import i3c_target_pkg::*; ();

  localparam int TMO = 64;

  logic  clk_i, rst_ni, target_enable_i;
  logic  bus_start_det_i, bus_rstart_det_i, bus_stop_det_i;
  logic  bus_rx_done_i, bus_tx_done_i;
  byte_t bus_rx_data_i;
  logic  bus_rx_req_byte_o, bus_rx_req_bit_o, bus_tx_req_byte_o, bus_tx_req_bit_o;
  byte_t bus_tx_req_value_o;
  addr_t target_sta_address_i, target_dyn_address_i;
  addr_t virtual_sta_address_i, virtual_dyn_address_i;
  logic  target_sta_address_valid_i, target_dyn_address_valid_i;
  logic  virtual_sta_address_valid_i, virtual_dyn_address_valid_i;
  logic  tx_desc_avail_i, tx_fifo_rvalid_i, tx_last_byte_i, rx_fifo_wready_i;
  byte_t tx_fifo_rdata_i;
  logic  tx_fifo_rready_o, rx_fifo_wvalid_o, rx_last_byte_o;
  byte_t rx_fifo_wdata_o, last_addr_o;
  logic  target_idle_o, target_transmitting_o, event_target_nack_o, last_addr_valid_o;
  logic  virtual_device_sel_o, xfer_in_progress_o, parity_err_o, rx_overflow_err_o;

  integer seed = 45395;
  integer errors = 0;
  integer timeouts = 0;
  integer pops = 0;
  logic   perr;

  i3c_target i3c_target_inst (.*);

  always #2 clk_i = ~clk_i;

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    timeouts++;
  endtask

  function automatic int phy_delay();
    return ($random(seed) & 3) + 1;
  endfunction

  // Odd parity over byte plus T-bit
  function automatic logic odd_tbit(input byte_t b);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) begin
      ones += b[i];
    end
    return (ones % 2) == 0;
  endfunction

  // Target only listens while an RX request is up
  task automatic wait_rx_req(input logic is_bit, output logic ok);
    int t;
    t = 0;
    while (!(is_bit ? bus_rx_req_bit_o : bus_rx_req_byte_o) && t < TMO) begin
      @(negedge clk_i);
      t++;
    end
    ok = (t < TMO);
    if (!ok) report_timeout(is_bit ? "RX bit request" : "RX byte request");
    else check_bit("target_transmitting_o", target_transmitting_o, 1'b0);
  endtask

  // PHY delivers a byte or bit; parity_err_o is sampled in the done cycle
  task automatic rx_phy(input byte_t data, input logic is_bit, output logic perr_o);
    logic ok;
    perr_o = 1'b0;
    wait_rx_req(is_bit, ok);
    if (ok) begin
      repeat (phy_delay()) @(negedge clk_i);
      bus_rx_data_i = data;
      bus_rx_done_i = 1'b1;
      #1 perr_o = parity_err_o;
      @(negedge clk_i);
      bus_rx_done_i = 1'b0;
    end
  endtask

  // PHY sends what the DUT requests and checks the value
  task automatic tx_phy(input logic is_bit, input byte_t exp);
    int t;
    t = 0;
    while (!(is_bit ? bus_tx_req_bit_o : bus_tx_req_byte_o) && t < TMO) begin
      @(negedge clk_i);
      t++;
    end
    if (t >= TMO) begin
      report_timeout(is_bit ? "TX bit request" : "TX byte request");
    end else begin
      check_byte("bus_tx_req_value_o", bus_tx_req_value_o, exp);
      check_bit("target_transmitting_o", target_transmitting_o, 1'b1);
      repeat (phy_delay()) @(negedge clk_i);
      bus_tx_done_i = 1'b1;
      #1 if (tx_fifo_rready_o) pops++;
      @(negedge clk_i);
      bus_tx_done_i = 1'b0;
    end
  endtask

  task automatic start_pulse(input logic rep);
    if (rep) bus_rstart_det_i = 1'b1;
    else     bus_start_det_i  = 1'b1;
    @(negedge clk_i);
    bus_start_det_i  = 1'b0;
    bus_rstart_det_i = 1'b0;
  endtask

  // STOP flags the last write byte and idles the target on the next cycle
  task automatic stop_and_check_idle(input logic last_exp);
    bus_stop_det_i = 1'b1;
    #1 check_bit("rx_last_byte_o", rx_last_byte_o, last_exp);
    @(negedge clk_i);
    bus_stop_det_i = 1'b0;
    check_bit("target_idle_o", target_idle_o, 1'b1);
  endtask

  task automatic send_addr(input addr_t a, input logic rnw);
    logic p;
    start_pulse(1'b0);
    rx_phy({a, rnw}, 1'b0, p);
  endtask

  task automatic write_byte(input byte_t b, input logic good, output logic perr_o);
    logic p;
    rx_phy(b, 1'b0, p);
    rx_phy({7'h00, odd_tbit(b) ^ !good}, 1'b1, perr_o);
  endtask

  task automatic expect_write(input byte_t b);
    int t;
    t = 0;
    while (!rx_fifo_wvalid_o && t < TMO) begin
      @(negedge clk_i);
      t++;
    end
    if (t >= TMO) report_timeout("rx_fifo_wvalid_o");
    else check_byte("rx_fifo_wdata_o", rx_fifo_wdata_o, b);
  endtask

  // NACK event must come once, with no ACK request, and the target stays busy
  task automatic expect_nack();
    int   t;
    int   extra;
    logic acked;
    t = 0;
    extra = 0;
    acked = 1'b0;
    while (!event_target_nack_o && t < TMO) begin
      if (bus_tx_req_bit_o) acked = 1'b1;
      @(negedge clk_i);
      t++;
    end
    if (t >= TMO) report_timeout("event_target_nack_o");
    check_bit("bus_tx_req_bit_o", acked, 1'b0);
    repeat (8) begin
      @(negedge clk_i);
      if (event_target_nack_o) extra++;
      check_bit("target_idle_o", target_idle_o, 1'b0);
    end
    check_byte("event_target_nack_o extra pulses", byte_t'(extra), 8'h00);
  endtask

  task automatic expect_overflow();
    int t;
    t = 0;
    while (!rx_overflow_err_o && t < TMO) begin
      @(negedge clk_i);
      t++;
    end
    if (t >= TMO) report_timeout("rx_overflow_err_o");
  endtask

  task automatic test_private_write();
    send_addr(7'h33, 1'b0);
    tx_phy(1'b1, 8'h00);
    check_bit("xfer_in_progress_o", xfer_in_progress_o, 1'b1);
    write_byte(8'hA5, 1'b1, perr);
    check_bit("parity_err_o", perr, 1'b0);
    expect_write(8'hA5);
    write_byte(8'h3C, 1'b1, perr);
    check_bit("parity_err_o", perr, 1'b0);
    expect_write(8'h3C);
    write_byte(8'hF0, 1'b1, perr);
    check_bit("parity_err_o", perr, 1'b0);
    expect_write(8'hF0);
    stop_and_check_idle(1'b1);
  endtask

  task automatic test_precedence();
    target_dyn_address_valid_i = 1'b0;
    send_addr(7'h21, 1'b0);
    tx_phy(1'b1, 8'h00);
    stop_and_check_idle(1'b1);
    target_dyn_address_valid_i = 1'b1;
    send_addr(7'h21, 1'b0);
    expect_nack();
    check_bit("xfer_in_progress_o", xfer_in_progress_o, 1'b0);
    stop_and_check_idle(1'b0);
  endtask

  task automatic test_private_read();
    tx_fifo_rdata_i  = 8'hD0;
    tx_fifo_rvalid_i = 1'b1;
    tx_last_byte_i   = 1'b0;
    pops = 0;
    send_addr(7'h33, 1'b1);
    tx_phy(1'b1, 8'h00);
    tx_phy(1'b0, 8'hD0);
    // Second byte is the last one in the FIFO
    tx_fifo_rdata_i = 8'hD1;
    tx_last_byte_i  = 1'b1;
    tx_phy(1'b1, 8'h01);
    tx_phy(1'b0, 8'hD1);
    tx_phy(1'b1, 8'h00);
    check_byte("tx_fifo_rready_o pulses", byte_t'(pops), 8'h02);
    tx_fifo_rvalid_i = 1'b0;
    tx_last_byte_i   = 1'b0;
    stop_and_check_idle(1'b0);
  endtask

  task automatic test_parity_error();
    send_addr(7'h33, 1'b0);
    tx_phy(1'b1, 8'h00);
    write_byte(8'h5A, 1'b0, perr);
    check_bit("parity_err_o", perr, 1'b1);
    repeat (4) begin
      check_bit("rx_fifo_wvalid_o", rx_fifo_wvalid_o, 1'b0);
      @(negedge clk_i);
    end
    stop_and_check_idle(1'b1);
  endtask

  task automatic test_broadcast(input logic desc);
    logic ok;
    logic p;
    tx_desc_avail_i  = desc;
    tx_fifo_rdata_i  = 8'h77;
    tx_fifo_rvalid_i = 1'b1;
    start_pulse(1'b0);
    rx_phy(RSVD_BYTE, 1'b0, p);
    tx_phy(1'b1, 8'h00);
    // Repeated START once the second byte is requested
    wait_rx_req(1'b0, ok);
    if (ok) start_pulse(1'b1);
    rx_phy({7'h45, 1'b1}, 1'b0, p);
    if (desc) begin
      tx_phy(1'b1, 8'h00);
      check_bit("virtual_device_sel_o", virtual_device_sel_o, 1'b1);
      check_bit("xfer_in_progress_o", xfer_in_progress_o, 1'b1);
      check_byte("last_addr_o", last_addr_o, 8'h8B);
      check_bit("last_addr_valid_o", last_addr_valid_o, 1'b1);
    end else begin
      expect_nack();
    end
    tx_fifo_rvalid_i = 1'b0;
    stop_and_check_idle(1'b0);
  endtask

  task automatic test_backpressure();
    send_addr(7'h33, 1'b0);
    rx_fifo_wready_i = 1'b0;
    tx_phy(1'b1, 8'h00);
    expect_overflow();
    write_byte(8'h99, 1'b1, perr);
    check_bit("rx_fifo_wvalid_o", rx_fifo_wvalid_o, 1'b0);
    rx_fifo_wready_i = 1'b1;
    @(negedge clk_i);
    check_bit("rx_fifo_wvalid_o", rx_fifo_wvalid_o, 1'b0);
    stop_and_check_idle(1'b1);
  endtask

  initial begin
    clk_i = 1'b0;
    rst_ni = 1'b0;
    target_enable_i = 1'b1;
    bus_start_det_i = 1'b0;
    bus_rstart_det_i = 1'b0;
    bus_stop_det_i = 1'b0;
    bus_rx_done_i = 1'b0;
    bus_rx_data_i = 8'h00;
    bus_tx_done_i = 1'b0;
    target_sta_address_i = 7'h21;
    target_sta_address_valid_i = 1'b1;
    target_dyn_address_i = 7'h33;
    target_dyn_address_valid_i = 1'b1;
    virtual_sta_address_i = 7'h45;
    virtual_sta_address_valid_i = 1'b1;
    virtual_dyn_address_i = 7'h00;
    virtual_dyn_address_valid_i = 1'b0;
    tx_desc_avail_i = 1'b0;
    tx_fifo_rvalid_i = 1'b0;
    tx_fifo_rdata_i = 8'h00;
    tx_last_byte_i = 1'b0;
    rx_fifo_wready_i = 1'b1;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    check_bit("target_idle_o", target_idle_o, 1'b1);
    check_bit("last_addr_valid_o", last_addr_valid_o, 1'b0);
    test_private_write();
    test_precedence();
    test_private_read();
    test_parity_error();
    test_broadcast(1'b1);
    test_broadcast(1'b0);
    test_backpressure();
    $display("Errors: %0d  Timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== project.f ====
design/i3c_target_pkg.sv
design/target_addr_match.sv
design/target_fsm.sv
design/target_rx_path.sv
design/target_tx_path.sv
design/i3c_target.sv
bench/tb_i3c_target.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f project.f --top-module tb_i3c_target -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "TEST RESULT: PASS"
